//--- tb.f
design/beam_pkg.sv
design/display_timings.sv
design/square_motion.sv
design/square_painter.sv
design/beam_regs.sv
design/beam_top.sv
bench/tb_clock.sv
bench/tb_beam.sv

//--- Makefile
# Verilator build for the beam generator testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_beam
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_beam.sv
// **************************************************
// testbench for the beam generator on a tiny screen
// pixel model every cycle, AXI4-Lite register traffic
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module tb_beam;

    localparam int h_active = 32;
    localparam int h_fp     = 2;
    localparam int h_sync   = 4;
    localparam int h_bp     = 2;
    localparam int v_active = 16;
    localparam int v_fp     = 1;
    localparam int v_sync   = 2;
    localparam int v_bp     = 1;
    localparam int q_size   = 4;
    localparam int h_total  = h_active + h_fp + h_sync + h_bp;  // 40
    localparam int v_total  = v_active + v_fp + v_sync + v_bp;  // 20
    localparam int hs_start = h_active + h_fp;
    localparam int vs_start = v_active + v_fp;
    localparam int frame_cycles = h_total * v_total;
    localparam int clk_ns = 8;
    // sequence runs about ten frames
    localparam int watchdog_ns = (12 * frame_cycles + 500) * clk_ns;

    logic                       clk_pix, rst_n;
    logic [4:0]                 awaddr, araddr;
    logic                       awvalid, awready, wvalid, wready, bvalid, bready;
    logic                       arvalid, arready, rvalid, rready;
    logic [31:0]                wdata, rdata;
    beam_pkg::axi_resp_t        bresp, rresp;
    logic                       dvi_hsync, dvi_vsync, dvi_de;
    logic [beam_pkg::colrw-1:0] dvi_r, dvi_g, dvi_b;

    // register contents as written over the bus
    logic        sh_en;
    logic [3:0]  sh_speed;
    logic [11:0] sh_fg, sh_bg;

    int          m_sx, m_sy, m_qx, m_qy;  // counters in the current cycle
    int          p_sx, p_sy, p_qx, p_qy;  // one cycle back, what the outputs show
    logic [11:0] p_fg, p_bg;
    int          frames;                  // blank_start events so far
    int          cnt_now;                 // frame_count held this cycle
    bit          was_live;                // rst_n at the previous falling edge
    bit          wr_busy;                 // write response owed by the DUT
    bit          rd_busy;                 // read response owed by the DUT

    tb_clock #(.half_ns(clk_ns / 2), .rst_cycles(3)) clock_inst (
        .clk_pix(clk_pix),
        .rst_n  (rst_n)
    );

    beam_top #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp),
        .q_size(q_size)
    ) beam_top_inst (
        .clk_pix(clk_pix), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .dvi_hsync(dvi_hsync), .dvi_vsync(dvi_vsync), .dvi_de(dvi_de),
        .dvi_r(dvi_r), .dvi_g(dvi_g), .dvi_b(dvi_b)
    );

    task automatic stop_failed();
        $display("Test failures found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("ERR %0d ns: %s", $time, msg);
        stop_failed();
    endtask

    // expected {hsync, vsync, de, r, g, b} for one scan position
    function automatic logic [14:0] pixel_ref(input int sx, input int sy, input int qx,
                                              input int qy, input logic [11:0] fg,
                                              input logic [11:0] bg);
        logic        hs, vs, de, hit;
        logic [11:0] col;
        hs  = !(sx >= hs_start && sx < hs_start + h_sync);  // active low
        vs  = !(sy >= vs_start && sy < vs_start + v_sync);
        de  = (sx < h_active) && (sy < v_active);
        hit = (sx >= qx) && (sx < qx + q_size) && (sy >= qy) && (sy < qy + q_size);
        col = 12'h000;  // black outside the active area
        if (de) col = hit ? fg : bg;
        return {hs, vs, de, col};
    endfunction

    // register map as seen from the bus
    function automatic void read_ref(input logic [4:0] addr, output logic [31:0] data,
                                     output beam_pkg::axi_resp_t resp);
        data = 32'h0;
        resp = beam_pkg::okay;
        case (addr)
            beam_pkg::ctrl:        data = {31'h0, sh_en};
            beam_pkg::speed:       data = {28'h0, sh_speed};
            beam_pkg::fg_color:    data = {20'h0, sh_fg};
            beam_pkg::bg_color:    data = {20'h0, sh_bg};
            beam_pkg::frame_count: data = {16'h0, 16'(cnt_now)};
            default:               resp = beam_pkg::slverr;  // hole, reads zero
        endcase
    endfunction

    function automatic beam_pkg::axi_resp_t bresp_ref(input logic [4:0] addr);
        case (addr)
            beam_pkg::ctrl, beam_pkg::speed, beam_pkg::fg_color, beam_pkg::bg_color:
                return beam_pkg::okay;
            default:
                return beam_pkg::slverr;
        endcase
    endfunction

    task automatic mirror_write(input logic [4:0] addr, input logic [31:0] data);
        case (addr)
            beam_pkg::ctrl:     sh_en    = data[0];
            beam_pkg::speed:    sh_speed = data[3:0];
            beam_pkg::fg_color: sh_fg    = data[11:0];
            beam_pkg::bg_color: sh_bg    = data[11:0];
            default: ;  // read-only and holes keep their state
        endcase
    endtask

    // one motion step, wraps at the line end then the frame end
    task automatic step_square();
        if (m_qx >= h_total - q_size) begin
            m_qx = 0;
            m_qy = (m_qy >= v_total - q_size) ? 0 : m_qy + q_size;
        end else begin
            m_qx = m_qx + int'(sh_speed);
        end
    endtask

    task automatic pixel_compare(input logic [14:0] got, input logic [14:0] exp);
        if (got !== exp)
            flag_mismatch($sformatf("pixel x %0d y %0d: got %h, expected %h (hs,vs,de,rgb)",
                                    p_sx, p_sy, got, exp));
    endtask

    // {awready, wready, bvalid, arready, rvalid}
    task automatic handshake_compare(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
            flag_mismatch($sformatf("handshake: got %b, expected %b (aw,w,b,ar,r)",
                                    got, exp));
    endtask

    task automatic read_compare(input logic [31:0] got_d, input beam_pkg::axi_resp_t got_r,
                                input logic [31:0] exp_d, input beam_pkg::axi_resp_t exp_r,
                                input logic [4:0] addr);
        if (got_d !== exp_d || got_r !== exp_r)
            flag_mismatch($sformatf("read %h: got %h resp %b, expected %h resp %b",
                                    addr, got_d, got_r, exp_d, exp_r));
    endtask

    task automatic bresp_compare(input beam_pkg::axi_resp_t got,
                                 input beam_pkg::axi_resp_t exp, input logic [4:0] addr);
        if (got !== exp)
            flag_mismatch($sformatf("write %h: bresp %b, expected %b", addr, got, exp));
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        int stall;
        @(posedge clk_pix);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        @(negedge clk_pix);
        while (!(awready && wready)) @(negedge clk_pix);
        @(posedge clk_pix);  // handshake edge, register loads here
        mirror_write(addr, data);
        wr_busy = 1'b1;
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        stall = $urandom_range(3, 0);  // bready back-pressure
        repeat (stall) begin
            @(posedge clk_pix);
            #1;
        end
        bready = 1'b1;
        @(negedge clk_pix);
        if (!bvalid) begin
            $display("write response for address %h went missing during the stall", addr);
            stop_failed();
        end
        bresp_compare(bresp, bresp_ref(addr), addr);
        @(posedge clk_pix);
        wr_busy = 1'b0;  // response taken on this edge
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr);
        int                  stall;
        logic [31:0]         exp_d;
        beam_pkg::axi_resp_t exp_r;
        @(posedge clk_pix);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk_pix);
        while (!arready) @(negedge clk_pix);
        @(posedge clk_pix);
        read_ref(addr, exp_d, exp_r);  // state sampled on the handshake edge
        rd_busy = 1'b1;
        #1;
        arvalid = 1'b0;
        stall = $urandom_range(3, 0);
        repeat (stall) begin
            @(posedge clk_pix);
            #1;
        end
        rready = 1'b1;
        @(negedge clk_pix);
        if (!rvalid) begin
            $display("read response for address %h went missing during the stall", addr);
            stop_failed();
        end
        read_compare(rdata, rresp, exp_d, exp_r, addr);
        @(posedge clk_pix);
        rd_busy = 1'b0;
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = cnt_now + n;
        while (cnt_now < target) @(posedge clk_pix);
    endtask

    // scan model and pixel compare, outputs are settled at the falling edge
    always @(negedge clk_pix) begin
        if (!rst_n || !was_live) begin
            // no live rising edge yet
            pixel_compare({dvi_hsync, dvi_vsync, dvi_de, dvi_r, dvi_g, dvi_b},
                          {1'b1, 1'b1, 1'b0, 12'h000});
            m_sx   = 0;
            m_sy   = 0;
            m_qx   = 0;
            m_qy   = 0;
            frames = 0;
        end else begin
            pixel_compare({dvi_hsync, dvi_vsync, dvi_de, dvi_r, dvi_g, dvi_b},
                          pixel_ref(p_sx, p_sy, p_qx, p_qy, p_fg, p_bg));
        end
        // aw and w only taken together, and never while a response is owed
        handshake_compare({awready, wready, bvalid, arready, rvalid},
                          {awvalid && wvalid && !wr_busy, awvalid && wvalid && !wr_busy,
                           wr_busy, !rd_busy, rd_busy});
        was_live = rst_n;
        p_sx    = m_sx;  // painter input this cycle
        p_sy    = m_sy;
        p_qx    = m_qx;
        p_qy    = m_qy;
        p_fg    = sh_fg;
        p_bg    = sh_bg;
        cnt_now = frames;
        if (m_sx == 0 && m_sy == v_active) begin  // blank start
            frames = frames + 1;
            if (sh_en) step_square();
        end
        if (m_sx == h_total - 1) begin
            m_sx = 0;
            m_sy = (m_sy == v_total - 1) ? 0 : m_sy + 1;
        end else begin
            m_sx = m_sx + 1;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: test still running after %0d ns, a handshake never came", watchdog_ns);
        stop_failed();
    end

    initial begin
        int          seed_ret;
        logic [31:0] d;
        logic [3:0]  spd;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        wr_busy   = 1'b0;
        rd_busy   = 1'b0;
        sh_en     = 1'b1;  // register reset values
        sh_speed  = 4'd4;
        sh_fg     = 12'hF80;
        sh_bg     = 12'h08F;
        seed_ret  = $urandom(32'ha516_bed7);
        @(posedge rst_n);

        read_reg(beam_pkg::ctrl);  // reset state over the bus
        read_reg(beam_pkg::speed);
        read_reg(beam_pkg::fg_color);
        read_reg(beam_pkg::bg_color);
        read_reg(beam_pkg::frame_count);

        write_reg(beam_pkg::fg_color, $urandom());  // upper bits dropped
        write_reg(beam_pkg::bg_color, $urandom());
        read_reg(beam_pkg::fg_color);
        read_reg(beam_pkg::bg_color);
        wait_frames(3);  // default speed steps

        // read-only counter and holes
        read_reg(beam_pkg::frame_count);
        write_reg(beam_pkg::frame_count, $urandom());
        write_reg(5'h14, $urandom());
        read_reg(5'h14);
        read_reg(5'h1C);
        read_reg(beam_pkg::frame_count);
        read_reg(beam_pkg::fg_color);
        read_reg(beam_pkg::speed);

        d = $urandom();
        write_reg(beam_pkg::ctrl, d & 32'hFFFF_FFFE);  // motion off
        read_reg(beam_pkg::ctrl);
        wait_frames(2);  // square must hold still

        spd = 4'($urandom_range(15, 8));
        d = $urandom();
        write_reg(beam_pkg::speed, {d[31:4], spd});
        read_reg(beam_pkg::speed);
        write_reg(beam_pkg::ctrl, 32'h1);
        write_reg(beam_pkg::bg_color, $urandom());
        wait_frames(5);  // enough steps for a line wrap
        read_reg(beam_pkg::frame_count);
        read_reg(beam_pkg::bg_color);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// **************************************************
// testbench clock and reset source
// 8 ns pixel clock, reset low for the first cycles
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_ns    = 4,  // half the pixel period
    parameter int rst_cycles = 3   // rising edges held in reset
) (
    output logic clk_pix,
    output logic rst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #(half_ns) clk_pix = ~clk_pix;
    end

    // release just after an edge, same offset as the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk_pix);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- design/beam_top.sv
// **************************************************
// beam generator top level
// timings, moving square, painter and AXI registers
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module beam_top #(
    parameter int h_active = 640,
    parameter int h_fp     = 16,
    parameter int h_sync   = 96,
    parameter int h_bp     = 48,
    parameter int v_active = 480,
    parameter int v_fp     = 10,
    parameter int v_sync   = 2,
    parameter int v_bp     = 33,
    parameter int q_size   = 32
) (
    input  wire logic                  clk_pix,  // from external clock gen
    input  wire logic                  rst_n,
    input  wire logic [4:0]            awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [31:0]           wdata,
    input  wire logic                  wvalid,
    output logic                       wready,
    output beam_pkg::axi_resp_t        bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [4:0]            araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output beam_pkg::axi_resp_t        rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    output logic                       dvi_hsync,
    output logic                       dvi_vsync,
    output logic                       dvi_de,
    output logic [beam_pkg::colrw-1:0] dvi_r,
    output logic [beam_pkg::colrw-1:0] dvi_g,
    output logic [beam_pkg::colrw-1:0] dvi_b
);

    logic [beam_pkg::cordw-1:0]   sx, sy;    // scan position
    logic [beam_pkg::cordw-1:0]   qx, qy;    // square corner
    logic                         hsync, vsync, de;
    logic                         blank_start;
    logic                         enable;
    logic [beam_pkg::spdw-1:0]    speed;
    logic [3*beam_pkg::colrw-1:0] fg_color, bg_color;

    display_timings #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) timings_inst (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .blank_start
    );

    // motion needs the full frame size for its wrap points
    square_motion #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp),
        .q_size(q_size)
    ) motion_inst (
        .clk_pix, .rst_n, .blank_start, .enable, .speed, .qx, .qy
    );

    square_painter #(.q_size(q_size)) painter_inst (
        .clk_pix, .rst_n, .sx, .sy, .de, .hsync, .vsync, .qx, .qy,
        .fg_color, .bg_color,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

    beam_regs regs_inst (
        .clk_pix, .rst_n, .blank_start,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .enable, .speed, .fg_color, .bg_color
    );

endmodule

`default_nettype wire

//--- design/beam_regs.sv
// **************************************************
// AXI4-Lite control registers for the beam design
// motion enable, speed, colours and frame counter
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module beam_regs (
    input  wire logic                      clk_pix,
    input  wire logic                      rst_n,
    input  wire logic                      blank_start,  // counts frames
    input  wire logic [4:0]                awaddr,
    input  wire logic                      awvalid,
    output logic                           awready,
    input  wire logic [31:0]               wdata,
    input  wire logic                      wvalid,
    output logic                           wready,
    output beam_pkg::axi_resp_t            bresp,
    output logic                           bvalid,
    input  wire logic                      bready,
    input  wire logic [4:0]                araddr,
    input  wire logic                      arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output beam_pkg::axi_resp_t            rresp,
    output logic                           rvalid,
    input  wire logic                      rready,
    output logic                           enable,
    output logic [beam_pkg::spdw-1:0]      speed,
    output logic [3*beam_pkg::colrw-1:0]   fg_color,
    output logic [3*beam_pkg::colrw-1:0]   bg_color
);

    localparam int sw = beam_pkg::spdw;
    localparam int colw = 3 * beam_pkg::colrw;  // packed r,g,b

    // power-up look, orange square on blue
    localparam logic            enable_rst = 1'b1;
    localparam logic [sw-1:0]   speed_rst  = sw'(4);
    localparam logic [colw-1:0] fg_rst     = colw'(12'hF80);
    localparam logic [colw-1:0] bg_rst     = colw'(12'h08F);

    beam_pkg::wr_state_t wr_state;
    beam_pkg::axi_resp_t wr_resp_nxt;  // response for the current aw
    beam_pkg::axi_resp_t rd_resp_nxt;
    logic                wr_hs;        // aw and w taken this cycle
    logic                rd_hs;
    logic [31:0]         rd_data_nxt;
    logic [15:0]         frame_cnt;

    always_comb begin
        wr_hs   = (wr_state == beam_pkg::wr_idle) && awvalid && wvalid;
        awready = wr_hs;   // both channels accepted together
        wready  = wr_hs;
        bvalid  = (wr_state == beam_pkg::wr_resp);
        arready = !rvalid; // one read in flight at most
        rd_hs   = arvalid && arready;
    end

    // write decode, only the four rw registers answer okay
    always_comb begin
        case (beam_pkg::reg_addr_t'(awaddr))
            beam_pkg::ctrl, beam_pkg::speed,
            beam_pkg::fg_color, beam_pkg::bg_color: wr_resp_nxt = beam_pkg::okay;
            default:                                wr_resp_nxt = beam_pkg::slverr;
        endcase
    end

    // read mux, unused bits zero
    always_comb begin
        rd_data_nxt = '0;
        rd_resp_nxt = beam_pkg::okay;
        case (beam_pkg::reg_addr_t'(araddr))
            beam_pkg::ctrl:        rd_data_nxt[0]        = enable;
            beam_pkg::speed:       rd_data_nxt[sw-1:0]   = speed;
            beam_pkg::fg_color:    rd_data_nxt[colw-1:0] = fg_color;
            beam_pkg::bg_color:    rd_data_nxt[colw-1:0] = bg_color;
            beam_pkg::frame_count: rd_data_nxt[15:0]     = frame_cnt;
            default:               rd_resp_nxt           = beam_pkg::slverr;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            wr_state  <= beam_pkg::wr_idle;
            rvalid    <= 1'b0;
            enable    <= enable_rst;
            speed     <= speed_rst;
            fg_color  <= fg_rst;
            bg_color  <= bg_rst;
            frame_cnt <= '0;
        end else begin
            if (blank_start) frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
            case (wr_state)
                beam_pkg::wr_idle: if (wr_hs) begin
                    wr_state <= beam_pkg::wr_resp;
                    case (beam_pkg::reg_addr_t'(awaddr))
                        beam_pkg::ctrl:     enable   <= wdata[0];
                        beam_pkg::speed:    speed    <= wdata[sw-1:0];
                        beam_pkg::fg_color: fg_color <= wdata[colw-1:0];
                        beam_pkg::bg_color: bg_color <= wdata[colw-1:0];
                        default: ;  // read-only or unmapped, nothing stored
                    endcase
                end
                beam_pkg::wr_resp: if (bready) wr_state <= beam_pkg::wr_idle;
                default: wr_state <= beam_pkg::wr_idle;
            endcase
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;  // response taken
        end
    end

    // response payload, only looked at while valid
    always_ff @(posedge clk_pix) begin
        if (wr_hs) bresp <= wr_resp_nxt;
        if (rd_hs) begin
            rdata <= rd_data_nxt;
            rresp <= rd_resp_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/square_painter.sv
// **************************************************
// square painter and DVI output register
// picks square or background colour per pixel
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module square_painter #(
    parameter int q_size = 32
) (
    input  wire logic                          clk_pix,
    input  wire logic                          rst_n,
    input  wire logic [beam_pkg::cordw-1:0]    sx,
    input  wire logic [beam_pkg::cordw-1:0]    sy,
    input  wire logic                          de,
    input  wire logic                          hsync,
    input  wire logic                          vsync,
    input  wire logic [beam_pkg::cordw-1:0]    qx,
    input  wire logic [beam_pkg::cordw-1:0]    qy,
    input  wire logic [3*beam_pkg::colrw-1:0]  fg_color,  // r in top nibble
    input  wire logic [3*beam_pkg::colrw-1:0]  bg_color,
    output logic                               dvi_hsync,
    output logic                               dvi_vsync,
    output logic                               dvi_de,
    output logic [beam_pkg::colrw-1:0]         dvi_r,
    output logic [beam_pkg::colrw-1:0]         dvi_g,
    output logic [beam_pkg::colrw-1:0]         dvi_b
);

    localparam int cw = beam_pkg::cordw;
    localparam int cb = beam_pkg::colrw;

    // one extra bit so qx + q_size cannot wrap
    localparam logic [cw:0] q_ext = (cw + 1)'(q_size);

    logic          hit;        // pixel inside the square
    logic [3*cb-1:0] pix_color;

    always_comb begin
        hit = (sx >= qx) && ({1'b0, sx} < {1'b0, qx} + q_ext)
           && (sy >= qy) && ({1'b0, sy} < {1'b0, qy} + q_ext);
        pix_color = !de ? '0 : (hit ? fg_color : bg_color);  // black in blanking
    end

    // syncs go through the same stage as colour, keeps them aligned
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            dvi_hsync <= 1'b1;  // inactive
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
        end else begin
            dvi_hsync <= hsync;
            dvi_vsync <= vsync;
            dvi_de    <= de;
            dvi_r     <= pix_color[3*cb-1:2*cb];
            dvi_g     <= pix_color[2*cb-1:cb];
            dvi_b     <= pix_color[cb-1:0];
        end
    end

endmodule

`default_nettype wire

//--- design/square_motion.sv
// **************************************************
// square position, stepped once per frame
// wraps at the line end and at the frame end
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module square_motion #(
    parameter int h_active = 640,
    parameter int h_fp     = 16,
    parameter int h_sync   = 96,
    parameter int h_bp     = 48,
    parameter int v_active = 480,
    parameter int v_fp     = 10,
    parameter int v_sync   = 2,
    parameter int v_bp     = 33,
    parameter int q_size   = 32   // square edge in pixels
) (
    input  wire logic                      clk_pix,
    input  wire logic                      rst_n,
    input  wire logic                      blank_start,  // frame tick from timings
    input  wire logic                      enable,       // motion on
    input  wire logic [beam_pkg::spdw-1:0] speed,        // pixels per frame
    output logic [beam_pkg::cordw-1:0]     qx,           // top-left corner
    output logic [beam_pkg::cordw-1:0]     qy
);

    localparam int cw = beam_pkg::cordw;
    localparam int sw = beam_pkg::spdw;

    // wrap limits use the full screen, blanking included
    localparam int h_total = h_active + h_fp + h_sync + h_bp;
    localparam int v_total = v_active + v_fp + v_sync + v_bp;

    localparam logic [cw-1:0] qx_lim = cw'(h_total - q_size);
    localparam logic [cw-1:0] qy_lim = cw'(v_total - q_size);
    localparam logic [cw-1:0] q_step = cw'(q_size);  // row step

    logic [cw-1:0] speed_ext;
    always_comb speed_ext = {{(cw - sw){1'b0}}, speed};

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            qx <= '0;
            qy <= '0;
        end else if (blank_start && enable) begin
            if (qx >= qx_lim) begin  // past line end, drop a row
                qx <= '0;
                qy <= (qy >= qy_lim) ? '0 : qy + q_step;
            end else begin
                qx <= qx + speed_ext;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/display_timings.sv
// **************************************************
// display timing generator for the raster beam
// scans the frame and decodes sync and data enable
// **************************************************

`default_nettype none
`timescale 1ns/1ps

module display_timings #(
    parameter int h_active = 640,  // visible pixels per line
    parameter int h_fp     = 16,   // front porch
    parameter int h_sync   = 96,   // sync pulse width
    parameter int h_bp     = 48,   // back porch
    parameter int v_active = 480,  // visible lines
    parameter int v_fp     = 10,
    parameter int v_sync   = 2,
    parameter int v_bp     = 33
) (
    input  wire logic                      clk_pix,      // pixel clock
    input  wire logic                      rst_n,        // async reset, active low
    output logic [beam_pkg::cordw-1:0]     sx,           // horizontal position
    output logic [beam_pkg::cordw-1:0]     sy,           // vertical position
    output logic                           hsync,        // active low
    output logic                           vsync,        // active low
    output logic                           de,           // data enable
    output logic                           blank_start   // one tick per frame
);

    localparam int cw = beam_pkg::cordw;

    // line and frame length including blanking
    localparam int h_total = h_active + h_fp + h_sync + h_bp;
    localparam int v_total = v_active + v_fp + v_sync + v_bp;

    // decode points, sized to the counters
    localparam logic [cw-1:0] h_last   = cw'(h_total - 1);
    localparam logic [cw-1:0] v_last   = cw'(v_total - 1);
    localparam logic [cw-1:0] h_vis    = cw'(h_active);
    localparam logic [cw-1:0] v_vis    = cw'(v_active);
    localparam logic [cw-1:0] hs_start = cw'(h_active + h_fp);
    localparam logic [cw-1:0] hs_end   = cw'(h_active + h_fp + h_sync);  // exclusive
    localparam logic [cw-1:0] vs_start = cw'(v_active + v_fp);
    localparam logic [cw-1:0] vs_end   = cw'(v_active + v_fp + v_sync);

    // pixel and line counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_last) begin  // end of line
            sx <= '0;
            sy <= (sy == v_last) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode straight from the counters
    always_comb begin
        hsync = ~((sx >= hs_start) && (sx < hs_end));  // low inside sync window
        vsync = ~((sy >= vs_start) && (sy < vs_end));
        de    = (sx < h_vis) && (sy < v_vis);
        // first pixel of the first blank line
        blank_start = (sx == '0) && (sy == v_vis);
    end

endmodule

`default_nettype wire

//--- design/beam_pkg.sv
// **************************************************
// shared widths and encodings for the beam design
// register map offsets and AXI4-Lite enums
// **************************************************

`default_nettype none

package beam_pkg;

    // screen coordinate width in bits
    localparam int cordw = 10;

    // one colour channel, DVI Pmod is 4 bits per channel
    localparam int colrw = 4;

    localparam int spdw = 4;  // pixels per frame field

    // register byte offsets on the 5-bit AXI address
    typedef enum logic [4:0] {
        ctrl        = 5'h00,  // bit 0 motion enable
        speed       = 5'h04,  // step size, bits 3:0
        fg_color    = 5'h08,  // square colour r,g,b
        bg_color    = 5'h0C,  // background colour
        frame_count = 5'h10   // read only
    } reg_addr_t;

    // AXI response codes, only the two we return
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axi_resp_t;

    // write channel FSM
    typedef enum logic {
        wr_idle,  // waiting for aw and w together
        wr_resp   // bvalid held until bready
    } wr_state_t;

endpackage

`default_nettype wire
